//--- vlog.f
verilog/hazard_pkg.sv
verilog/issue_bus_if.sv
verilog/commit_bus_if.sv
verilog/issue_stage.sv
verilog/long_op_scoreboard.sv
verilog/long_exec_units.sv
verilog/long_issue_top.sv
bench/tb_long_issue.sv

//--- Makefile
TOP       ?= tb_long_issue
RTL_TOP   ?= long_issue_top
VERILATOR ?= verilator
FLIST     ?= vlog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
PASS_MSG = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(FLIST) $(wildcard verilog/*.sv bench/*.sv)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_long_issue.sv
// long-op issue path testbench
`default_nettype none

module tb_long_issue;

    localparam int DEPTH      = 8;
    localparam int ID_W       = $clog2(DEPTH);
    localparam int N_DIRECTED = 19;
    localparam int N_RAND     = 200;
    localparam int N_TOTAL    = N_DIRECTED + N_RAND;
    localparam int WD_CYCLES  = N_TOTAL * (hazard_pkg::DIV_CYCLES + 4) + 20;

    typedef logic [ID_W-1:0] id_t;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid_i;
    hazard_pkg::reg_addr_t rd_addr_i;
    hazard_pkg::reg_addr_t rs1_addr_i;
    hazard_pkg::reg_addr_t rs2_addr_i;
    logic                  rd_we_i;
    logic                  rs1_re_i;
    logic                  rs2_re_i;
    hazard_pkg::exu_type_t exu_type_i;
    logic                  inst_ready_o;
    logic                  issue_valid_o;
    id_t                   issue_id_o;
    logic                  hazard_stall_o;
    hazard_pkg::pass_vec_t pass_o;
    logic                  atom_lock_o;
    logic                  commit_valid1_o;
    id_t                   commit_id1_o;
    logic                  commit_valid2_o;
    id_t                   commit_id2_o;

    // reference table fed from issue and commit outputs only
    logic [DEPTH-1:0]      mdl_valid;
    hazard_pkg::reg_addr_t mdl_rd  [DEPTH];
    hazard_pkg::exu_type_t mdl_exu [DEPTH];
    int                    mdl_t   [DEPTH]; // issue cycle per entry
    logic                  held_full;       // copy of the issue register
    hazard_pkg::reg_addr_t h_rd;
    hazard_pkg::reg_addr_t h_rs1;
    hazard_pkg::reg_addr_t h_rs2;
    logic                  h_rd_we;
    logic                  h_rs1_re;
    logic                  h_rs2_re;
    hazard_pkg::exu_type_t h_exu;
    logic                  alu_live;        // last alu writer outstanding
    id_t                   alu_id;
    int                    cyc;
    int                    n_sent;
    int                    n_issued;
    int                    n_commits;
    int                    err_count;
    int unsigned           lcg_state;

    logic [DEPTH-1:0]      cmt_vec;
    logic [DEPTH-1:0]      live_vec;
    logic [DEPTH-1:0]      raw_vec;
    logic [DEPTH-1:0]      waw_vec;
    logic                  div_out;
    logic                  bypass;
    logic                  presented;
    logic                  exp_stall;
    id_t                   exp_id;
    logic                  fwd1;
    logic                  fwd2;
    hazard_pkg::pass_vec_t exp_pass;
    int                    lat1;
    int                    lat2;

    long_issue_top #(.DEPTH(DEPTH)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned rand_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16; // upper bits spread better
    endfunction

    function automatic hazard_pkg::reg_addr_t pick_reg();
        return hazard_pkg::reg_addr_t'(1 + rand_next() % 4); // x1..x4 only
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int act);
        err_count++;
        $display("[FAIL] %s expected %0d actual %0d (cycle %0d)", name, exp, act, cyc);
    endtask

    task automatic report_problem(input string msg);
        err_count++;
        $display("error at cycle %0d: %s", cyc, msg);
    endtask

    // expected responses from the reference state
    always_comb begin
        div_out = 1'b0;
        bypass  = h_exu == hazard_pkg::EXU_ALU || h_exu == hazard_pkg::EXU_CSR;
        for (int i = 0; i < DEPTH; i++) begin
            cmt_vec[i]  = (commit_valid1_o && commit_id1_o == id_t'(i)) ||
                          (commit_valid2_o && commit_id2_o == id_t'(i));
            live_vec[i] = mdl_valid[i] && !cmt_vec[i]; // committing entries drop out
            raw_vec[i]  = live_vec[i] && ((h_rs1_re && h_rs1 == mdl_rd[i]) ||
                                          (h_rs2_re && h_rs2 == mdl_rd[i]));
            if (bypass && alu_live && alu_id == id_t'(i))
                raw_vec[i] = 1'b0;
            waw_vec[i]  = live_vec[i] && h_rd_we && h_rd == mdl_rd[i] && h_exu != mdl_exu[i];
            if (mdl_valid[i] && mdl_exu[i] == hazard_pkg::EXU_DIV)
                div_out = 1'b1;
        end
        presented = held_full && !(h_exu == hazard_pkg::EXU_DIV && div_out);
        exp_stall = |raw_vec || |waw_vec || &live_vec;
        exp_id    = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
            if (cmt_vec[i]) exp_id = id_t'(i);
        for (int i = DEPTH - 1; i >= 0; i--)
            if (!mdl_valid[i]) exp_id = id_t'(i); // truly free slot preferred
        fwd1 = alu_live && h_rs1_re && h_rs1 == mdl_rd[alu_id];
        fwd2 = alu_live && h_rs2_re && h_rs2 == mdl_rd[alu_id];
        case (h_exu)
            hazard_pkg::EXU_ALU: exp_pass = {fwd1, fwd2, 5'b0};
            hazard_pkg::EXU_MUL: exp_pass = {2'b0, fwd1, fwd2, 3'b0};
            hazard_pkg::EXU_DIV: exp_pass = {4'b0, fwd1, fwd2, 1'b0};
            default:             exp_pass = {6'b0, fwd1}; // csr reads op1 only
        endcase
        lat1 = cyc - mdl_t[commit_id1_o];
        lat2 = cyc - mdl_t[commit_id2_o];
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mdl_valid <= '0;
            held_full <= 1'b0;
            h_exu     <= hazard_pkg::EXU_ALU;
            h_rd_we   <= 1'b0;
            h_rs1_re  <= 1'b0;
            h_rs2_re  <= 1'b0;
            alu_live  <= 1'b0;
            alu_id    <= '0;
            cyc       <= 0;
            n_issued  <= 0;
            n_commits <= 0;
        end else begin
            cyc       <= cyc + 1;
            n_commits <= n_commits + int'(commit_valid1_o) + int'(commit_valid2_o);
            if (commit_valid1_o) mdl_valid[commit_id1_o] <= 1'b0;
            if (commit_valid2_o) mdl_valid[commit_id2_o] <= 1'b0;
            if (issue_valid_o) begin // set after clear for same slot reuse
                mdl_valid[issue_id_o] <= 1'b1;
                mdl_rd[issue_id_o]    <= h_rd;
                mdl_exu[issue_id_o]   <= h_exu;
                mdl_t[issue_id_o]     <= cyc;
                held_full             <= 1'b0;
                n_issued              <= n_issued + 1;
            end
            if (commit_valid1_o && commit_id1_o == alu_id) alu_live <= 1'b0;
            if (issue_valid_o && h_exu == hazard_pkg::EXU_ALU && h_rd_we) begin
                alu_live <= 1'b1;
                alu_id   <= issue_id_o;
            end
            if (inst_valid_i && inst_ready_o) begin
                held_full <= 1'b1;
                h_rd      <= rd_addr_i;
                h_rs1     <= rs1_addr_i;
                h_rs2     <= rs2_addr_i;
                h_rd_we   <= rd_we_i;
                h_rs1_re  <= rs1_re_i;
                h_rs2_re  <= rs2_re_i;
                h_exu     <= exu_type_i;
            end
        end
    end

    a_lock: assert property (@(posedge clk) disable iff (!rst_n)
        atom_lock_o == |mdl_valid)
        else report_mismatch("atom_lock", int'($sampled(|mdl_valid)), int'($sampled(atom_lock_o)));
    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        inst_ready_o == (!held_full || issue_valid_o))
        else report_mismatch("inst_ready", int'($sampled(!held_full || issue_valid_o)),
                             int'($sampled(inst_ready_o)));
    a_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid_o == (presented && !exp_stall))
        else report_mismatch("issue", int'($sampled(presented && !exp_stall)),
                             int'($sampled(issue_valid_o)));
    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        presented |-> hazard_stall_o == exp_stall)
        else report_mismatch("stall", int'($sampled(exp_stall)), int'($sampled(hazard_stall_o)));
    a_id: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid_o |-> issue_id_o == exp_id)
        else report_mismatch("issue_id", int'($sampled(exp_id)), int'($sampled(issue_id_o)));
    a_pass: assert property (@(posedge clk) disable iff (!rst_n)
        presented |-> pass_o == exp_pass)
        else report_mismatch("pass", int'($sampled(exp_pass)), int'($sampled(pass_o)));
    a_c1_live: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid1_o |-> mdl_valid[commit_id1_o] && mdl_exu[commit_id1_o][1] == 1'b0)
        else report_problem("port 1 committed an id that holds no alu or csr op");
    a_c2_live: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid2_o |-> mdl_valid[commit_id2_o] && mdl_exu[commit_id2_o][1] == 1'b1)
        else report_problem("port 2 committed an id that holds no mul or div op");
    a_c_dual: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid1_o && commit_valid2_o |-> commit_id1_o != commit_id2_o)
        else report_problem("both commit ports carry the same id");
    a_c1_lat: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid1_o |-> lat1 == 1)
        else report_mismatch("alu/csr latency", 1, $sampled(lat1));
    a_mul_lat: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid2_o && mdl_exu[commit_id2_o] == hazard_pkg::EXU_MUL |->
            lat2 == hazard_pkg::MUL_STAGES)
        else report_mismatch("mul latency", hazard_pkg::MUL_STAGES, $sampled(lat2));
    a_div_lat: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid2_o && mdl_exu[commit_id2_o] == hazard_pkg::EXU_DIV |->
            lat2 >= hazard_pkg::DIV_CYCLES)
        else report_mismatch("div latency min", hazard_pkg::DIV_CYCLES, $sampled(lat2));

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic send(input hazard_pkg::reg_addr_t rd, input hazard_pkg::reg_addr_t rs1,
                        input hazard_pkg::reg_addr_t rs2, input logic re1, input logic re2,
                        input hazard_pkg::exu_type_t exu);
        inst_valid_i = 1'b1;
        rd_addr_i    = rd;
        rs1_addr_i   = rs1;
        rs2_addr_i   = rs2;
        rd_we_i      = 1'b1;
        rs1_re_i     = re1;
        rs2_re_i     = re2;
        exu_type_i   = exu;
        while (!inst_ready_o) @(negedge clk); // ready only moves on rising edges
        @(negedge clk);
        inst_valid_i = 1'b0;
        n_sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic drain();
        while (held_full || atom_lock_o) @(negedge clk);
    endtask

    initial begin
        int unsigned           r;
        hazard_pkg::exu_type_t t;
        rst_n        = 1'b0;
        inst_valid_i = 1'b0;
        rd_addr_i    = '0;
        rs1_addr_i   = '0;
        rs2_addr_i   = '0;
        rd_we_i      = 1'b0;
        rs1_re_i     = 1'b0;
        rs2_re_i     = 1'b0;
        exu_type_i   = hazard_pkg::EXU_ALU;
        lcg_state    = 52;
        err_count    = 0;
        n_sent       = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (inst_ready_o && !atom_lock_o && !issue_valid_o &&
                !commit_valid1_o && !commit_valid2_o)
            else report_problem("outputs not idle after reset");

        send(5'd1, 5'd5, 5'd6, 1'b1, 1'b1, hazard_pkg::EXU_ALU); // back-to-back alu
        send(5'd2, 5'd5, 5'd6, 1'b1, 1'b1, hazard_pkg::EXU_ALU);
        send(5'd3, 5'd2, 5'd1, 1'b1, 1'b0, hazard_pkg::EXU_CSR); // reads the committing alu
        send(5'd1, 5'd5, 5'd6, 1'b1, 1'b1, hazard_pkg::EXU_MUL); // raw on mul result
        send(5'd4, 5'd1, 5'd0, 1'b1, 1'b0, hazard_pkg::EXU_ALU);
        send(5'd2, 5'd5, 5'd6, 1'b1, 1'b1, hazard_pkg::EXU_DIV); // waw across units
        send(5'd2, 5'd5, 5'd6, 1'b0, 1'b0, hazard_pkg::EXU_ALU);
        send(5'd3, 5'd5, 5'd6, 1'b1, 1'b1, hazard_pkg::EXU_MUL); // no waw within one unit
        send(5'd3, 5'd5, 5'd6, 1'b1, 1'b1, hazard_pkg::EXU_MUL);
        send(5'd4, 5'd5, 5'd6, 1'b1, 1'b1, hazard_pkg::EXU_DIV); // div behind div
        send(5'd5, 5'd7, 5'd8, 1'b1, 1'b1, hazard_pkg::EXU_DIV);
        drain();
        // mul commits collide with the div
        send(5'd6, 5'd9, 5'd9, 1'b1, 1'b1, hazard_pkg::EXU_DIV);
        for (int k = 0; k < 7; k++)
            send(hazard_pkg::reg_addr_t'(7 + k), 5'd20, 5'd21, 1'b1, 1'b1, hazard_pkg::EXU_MUL);
        drain();

        for (int n = 0; n < N_RAND; n++) begin
            r = rand_next();
            t = hazard_pkg::exu_type_t'(r[1:0]);
            send(pick_reg(), pick_reg(), pick_reg(), r[2], r[3] && t != hazard_pkg::EXU_CSR, t);
            if (r[5:4] == 2'b00)
                idle(1 + int'(r[7:6])); // random gap
        end
        drain();
        idle(2);

        assert (mdl_valid == '0) else report_problem("operations left outstanding");
        if (n_issued != n_sent) report_mismatch("issue count", n_sent, n_issued);
        if (n_commits != n_issued) report_mismatch("commit count", n_issued, n_commits);
        $display("sent %0d issued %0d committed %0d errors %0d",
                 n_sent, n_issued, n_commits, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // hung issue or missing commit
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, operations never completed", WD_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/long_issue_top.sv
// long-op issue path top
`default_nettype none

module long_issue_top #(
    parameter int DEPTH = 8
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          inst_valid_i,
    input  hazard_pkg::reg_addr_t        rd_addr_i,
    input  hazard_pkg::reg_addr_t        rs1_addr_i,
    input  hazard_pkg::reg_addr_t        rs2_addr_i,
    input  wire                          rd_we_i,
    input  wire                          rs1_re_i,
    input  wire                          rs2_re_i,
    input  hazard_pkg::exu_type_t        exu_type_i,
    output logic                         inst_ready_o,
    output logic                         issue_valid_o,
    output logic [$clog2(DEPTH)-1:0]     issue_id_o,
    output logic                         hazard_stall_o,
    output hazard_pkg::pass_vec_t        pass_o,
    output logic                         atom_lock_o,
    output logic                         commit_valid1_o,
    output logic [$clog2(DEPTH)-1:0]     commit_id1_o,
    output logic                         commit_valid2_o,
    output logic [$clog2(DEPTH)-1:0]     commit_id2_o
);

    issue_bus_if  #(.DEPTH(DEPTH)) iss_bus ();
    commit_bus_if #(.DEPTH(DEPTH)) cmt_bus ();

    issue_stage u_issue (
        .clk, .rst_n, .inst_valid_i, .rd_addr_i, .rs1_addr_i, .rs2_addr_i,
        .rd_we_i, .rs1_re_i, .rs2_re_i, .exu_type_i, .inst_ready_o,
        .iss (iss_bus.producer)
    );

    long_op_scoreboard #(.DEPTH(DEPTH)) u_sb (
        .clk, .rst_n, .iss (iss_bus.scoreboard), .cmt (cmt_bus.sink),
        .pass_o, .atom_lock_o
    );

    long_exec_units #(.DEPTH(DEPTH)) u_exu (
        .clk, .rst_n, .iss (iss_bus.consumer), .cmt (cmt_bus.source)
    );

    assign issue_valid_o   = iss_bus.valid && !iss_bus.stall; // issue event
    assign issue_id_o      = iss_bus.id;
    assign hazard_stall_o  = iss_bus.stall;
    assign commit_valid1_o = cmt_bus.valid1;
    assign commit_id1_o    = cmt_bus.id1;
    assign commit_valid2_o = cmt_bus.valid2;
    assign commit_id2_o    = cmt_bus.id2;

endmodule

`default_nettype wire

//--- verilog/long_exec_units.sv
// long-op execution latency model
`default_nettype none

module long_exec_units #(
    parameter int DEPTH = 8
) (
    input  wire           clk,
    input  wire           rst_n,
    issue_bus_if.consumer iss,
    commit_bus_if.source  cmt
);

    localparam int ID_W  = $clog2(DEPTH);
    localparam int LAST  = hazard_pkg::MUL_STAGES - 1;
    localparam int CNT_W = $clog2(hazard_pkg::DIV_CYCLES);
    typedef logic [ID_W-1:0]  id_t;
    typedef logic [CNT_W-1:0] cnt_t;

    logic        issue;
    logic        short_op;    // alu or csr
    logic        alu_v_q;
    id_t         alu_id_q;
    logic [0:LAST] mul_v_q;   // mul pipe valids
    id_t         mul_id_q [0:LAST];
    logic        div_busy_q;
    cnt_t        div_cnt_q;
    id_t         div_id_q;
    logic        div_done;
    logic        div_fire;

    assign issue    = iss.valid && !iss.stall;
    assign short_op = !iss.exu[1];

    // single cycle alu/csr
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) alu_v_q <= 1'b0;
        else        alu_v_q <= issue && short_op;
    end

    always_ff @(posedge clk) begin
        if (issue && short_op) alu_id_q <= iss.id;
    end

    // mul shift pipe, one issue per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_v_q <= '0;
        end else begin
            mul_v_q[0] <= issue && iss.exu == hazard_pkg::EXU_MUL;
            for (int i = 1; i <= LAST; i++) mul_v_q[i] <= mul_v_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        mul_id_q[0] <= iss.id;
        for (int i = 1; i <= LAST; i++) mul_id_q[i] <= mul_id_q[i-1];
    end

    // iterative divider, yields port 2 to the mul pipe
    assign div_done = div_busy_q && div_cnt_q == '0;
    assign div_fire = div_done && !mul_v_q[LAST];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_busy_q <= 1'b0;
            div_cnt_q  <= '0;
        end else if (issue && iss.exu == hazard_pkg::EXU_DIV) begin
            div_busy_q <= 1'b1;
            div_cnt_q  <= cnt_t'(hazard_pkg::DIV_CYCLES - 1);
        end else if (div_fire) begin
            div_busy_q <= 1'b0;
        end else if (div_busy_q && !div_done) begin
            div_cnt_q <= div_cnt_q - 1'b1; // holds at zero while blocked
        end
    end

    always_ff @(posedge clk) begin
        if (issue && iss.exu == hazard_pkg::EXU_DIV) div_id_q <= iss.id;
    end

    assign iss.div_busy = div_busy_q;

    assign cmt.valid1 = alu_v_q;
    assign cmt.id1    = alu_id_q;
    assign cmt.valid2 = mul_v_q[LAST] || div_fire;
    assign cmt.id2    = mul_v_q[LAST] ? mul_id_q[LAST] : div_id_q; // mul has priority

    // issue stage must hold a div while the divider is occupied
    a_div_single: assert property (@(posedge clk) disable iff (!rst_n)
        issue && iss.exu == hazard_pkg::EXU_DIV |-> !div_busy_q)
        else $error("div issued while divider busy");

endmodule

`default_nettype wire

//--- verilog/long_op_scoreboard.sv
// long-op hazard scoreboard
// raw/waw check, id allocation, forwarding flags
`default_nettype none

module long_op_scoreboard #(
    parameter int DEPTH = 8
) (
    input  wire                   clk,
    input  wire                   rst_n,
    issue_bus_if.scoreboard       iss,
    commit_bus_if.sink            cmt,
    output hazard_pkg::pass_vec_t pass_o,
    output logic                  atom_lock_o
);

    localparam int ID_W = $clog2(DEPTH);
    typedef logic [ID_W-1:0]  id_t;
    typedef logic [DEPTH-1:0] vec_t;

    vec_t                  valid_q;      // outstanding entries
    hazard_pkg::reg_addr_t rd_q  [DEPTH];
    hazard_pkg::exu_type_t exu_q [DEPTH];

    vec_t cmt_hit;    // entries freed this cycle
    vec_t live;       // outstanding and not committing
    vec_t raw_vec;
    vec_t waw_vec;
    vec_t alu_mask;   // hides the last alu writer
    vec_t free_now;
    logic table_full;
    logic bypass_ok;
    logic issue;

    id_t  alu_id_q;   // id of last alu writer
    logic alu_live_q;
    logic fwd_rs1;
    logic fwd_rs2;

    // lowest set bit or 0 if none
    function automatic id_t lowest(input vec_t vec);
        id_t r;
        r = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) r = id_t'(i);
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            cmt_hit[i] = (cmt.valid1 && cmt.id1 == id_t'(i)) ||
                         (cmt.valid2 && cmt.id2 == id_t'(i));
            raw_vec[i] = (iss.rs1_re && iss.rs1 == rd_q[i]) ||
                         (iss.rs2_re && iss.rs2 == rd_q[i]);
            // waw only across differing units
            waw_vec[i] = iss.rd_we && iss.rd == rd_q[i] && iss.exu != exu_q[i];
        end
    end

    assign live      = valid_q & ~cmt_hit;
    assign bypass_ok = !iss.exu[1]; // alu and csr
    assign alu_mask  = (bypass_ok && alu_live_q) ? ~(vec_t'(1) << alu_id_q) : '1;

    assign free_now   = ~valid_q;
    assign table_full = &live;     // a committing entry counts as free
    assign iss.stall  = |(raw_vec & live & alu_mask) || |(waw_vec & live) || table_full;

    // prefer a truly free slot, else reuse one being committed
    assign iss.id = (|free_now) ? lowest(free_now) : lowest(cmt_hit);
    assign issue  = iss.valid && !iss.stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (cmt_hit[i]) valid_q[i] <= 1'b0;
            end
            if (issue) valid_q[iss.id] <= 1'b1; // wins over a same-slot commit
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rd_q[iss.id]  <= iss.rd;
            exu_q[iss.id] <= iss.exu;
        end
    end

    // last alu writer tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_live_q <= 1'b0;
            alu_id_q   <= '0;
        end else begin
            if (cmt.valid1 && cmt.id1 == alu_id_q) alu_live_q <= 1'b0; // port 1 only
            if (issue && iss.exu == hazard_pkg::EXU_ALU && iss.rd_we) begin
                alu_live_q <= 1'b1;
                alu_id_q   <= iss.id;
            end
        end
    end

    // alu result forwardable up to its port 1 commit
    assign fwd_rs1 = alu_live_q && iss.rs1_re && iss.rs1 == rd_q[alu_id_q];
    assign fwd_rs2 = alu_live_q && iss.rs2_re && iss.rs2 == rd_q[alu_id_q];

    always_comb begin
        pass_o = '0;
        case (iss.exu)
            hazard_pkg::EXU_ALU: begin
                pass_o[hazard_pkg::PASS_ALU_OP1] = fwd_rs1;
                pass_o[hazard_pkg::PASS_ALU_OP2] = fwd_rs2;
            end
            hazard_pkg::EXU_MUL: begin
                pass_o[hazard_pkg::PASS_MUL_OP1] = fwd_rs1;
                pass_o[hazard_pkg::PASS_MUL_OP2] = fwd_rs2;
            end
            hazard_pkg::EXU_DIV: begin
                pass_o[hazard_pkg::PASS_DIV_OP1] = fwd_rs1;
                pass_o[hazard_pkg::PASS_DIV_OP2] = fwd_rs2;
            end
            default: pass_o[hazard_pkg::PASS_CSR_OP1] = fwd_rs1; // csr has no rs2
        endcase
    end

    assign atom_lock_o = |valid_q;

    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> !valid_q[iss.id] || cmt_hit[iss.id])
        else $error("issue into an outstanding entry");

    // execution block must only retire what was issued
    a_commit_live: assert property (@(posedge clk) disable iff (!rst_n)
        (cmt.valid1 |-> valid_q[cmt.id1]) and (cmt.valid2 |-> valid_q[cmt.id2]) and
        (cmt.valid1 && cmt.valid2 |-> cmt.id1 != cmt.id2))
        else $error("commit of a free entry");

endmodule

`default_nettype wire

//--- verilog/issue_stage.sv
// issue holding register
`default_nettype none

module issue_stage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   inst_valid_i,
    input  hazard_pkg::reg_addr_t rd_addr_i,
    input  hazard_pkg::reg_addr_t rs1_addr_i,
    input  hazard_pkg::reg_addr_t rs2_addr_i,
    input  wire                   rd_we_i,
    input  wire                   rs1_re_i,
    input  wire                   rs2_re_i,
    input  hazard_pkg::exu_type_t exu_type_i,
    output logic                  inst_ready_o,
    issue_bus_if.producer         iss
);

    logic                  full_q;
    logic                  div_hold; // divider still working on the previous div
    logic                  issuing;
    logic                  accept;
    hazard_pkg::reg_addr_t rd_q;
    hazard_pkg::reg_addr_t rs1_q;
    hazard_pkg::reg_addr_t rs2_q;
    logic                  rd_we_q;
    logic                  rs1_re_q;
    logic                  rs2_re_q;
    hazard_pkg::exu_type_t exu_q;

    assign div_hold     = (exu_q == hazard_pkg::EXU_DIV) && iss.div_busy;
    assign iss.valid    = full_q && !div_hold; // not presented while div busy
    assign issuing      = iss.valid && !iss.stall;
    assign inst_ready_o = !full_q || issuing; // allows back-to-back
    assign accept       = inst_valid_i && inst_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (issuing) begin
            full_q <= 1'b0;
        end
    end

    // payload, loads on accept only
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q     <= rd_addr_i;
            rs1_q    <= rs1_addr_i;
            rs2_q    <= rs2_addr_i;
            rd_we_q  <= rd_we_i;
            rs1_re_q <= rs1_re_i;
            rs2_re_q <= rs2_re_i;
            exu_q    <= exu_type_i;
        end
    end

    assign iss.rd     = rd_q;
    assign iss.rs1    = rs1_q;
    assign iss.rs2    = rs2_q;
    assign iss.rd_we  = rd_we_q;
    assign iss.rs1_re = rs1_re_q;
    assign iss.rs2_re = rs2_re_q;
    assign iss.exu    = exu_q;

    // stalled instruction must not change under the scoreboard
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        iss.valid && iss.stall |=> full_q &&
            $stable({rd_q, rs1_q, rs2_q, rd_we_q, rs1_re_q, rs2_re_q, exu_q}))
        else $error("held instruction changed under stall");

endmodule

`default_nettype wire

//--- verilog/commit_bus_if.sv
// dual commit bus
`default_nettype none

interface commit_bus_if #(
    parameter int DEPTH = 8
);
    localparam int ID_W = $clog2(DEPTH);

    logic            valid1; // alu/csr port
    logic [ID_W-1:0] id1;
    logic            valid2; // mul/div port
    logic [ID_W-1:0] id2;

    modport source (output valid1, id1, valid2, id2);
    modport sink   (input  valid1, id1, valid2, id2);
endinterface

`default_nettype wire

//--- verilog/issue_bus_if.sv
// issue bus
`default_nettype none

interface issue_bus_if #(
    parameter int DEPTH = 8
);
    localparam int ID_W = $clog2(DEPTH);

    logic                  valid;    // held instruction presented
    hazard_pkg::reg_addr_t rd;
    hazard_pkg::reg_addr_t rs1;
    hazard_pkg::reg_addr_t rs2;
    logic                  rd_we;
    logic                  rs1_re;
    logic                  rs2_re;
    hazard_pkg::exu_type_t exu;
    logic                  stall;    // from scoreboard
    logic [ID_W-1:0]       id;       // allocated commit id
    logic                  div_busy; // divider occupied

    modport producer   (output valid, rd, rs1, rs2, rd_we, rs1_re, rs2_re, exu,
                        input  stall, div_busy);
    modport scoreboard (input  valid, rd, rs1, rs2, rd_we, rs1_re, rs2_re, exu,
                        output stall, id);
    modport consumer   (input  valid, exu, stall, id,
                        output div_busy);
endinterface

`default_nettype wire

//--- verilog/hazard_pkg.sv
// long-op issue path
// shared types and latencies
`default_nettype none

package hazard_pkg;

    typedef logic [4:0] reg_addr_t; // x0..x31

    // upper bit low marks the bypass-capable units
    typedef enum logic [1:0] {
        EXU_ALU = 2'b00,
        EXU_CSR = 2'b01,
        EXU_MUL = 2'b10,
        EXU_DIV = 2'b11
    } exu_type_t;

    // forwarding flags, alu_op1 in the msb
    typedef logic [6:0] pass_vec_t;

    localparam int PASS_ALU_OP1 = 6;
    localparam int PASS_ALU_OP2 = 5;
    localparam int PASS_MUL_OP1 = 4;
    localparam int PASS_MUL_OP2 = 3;
    localparam int PASS_DIV_OP1 = 2;
    localparam int PASS_DIV_OP2 = 1;
    localparam int PASS_CSR_OP1 = 0;

    localparam int MUL_STAGES = 3; // mul pipe depth
    localparam int DIV_CYCLES = 8; // div iterations

endpackage

`default_nettype wire
